/* project.f */
+incdir+sim
source/backend_isa_pkg.sv
source/backend_cfg_pkg.sv
source/pkt_intake.sv
source/rename_dispatch.sv
source/reorder_buffer.sv
source/alu_exec.sv
source/commit_stage.sv
source/ooo_backend.sv
sim/tb_ooo_backend.sv

/* Bender.yml */
package:
  name: ooo_backend

sources:
  - source/backend_isa_pkg.sv
  - source/backend_cfg_pkg.sv
  - source/pkt_intake.sv
  - source/rename_dispatch.sv
  - source/reorder_buffer.sv
  - source/alu_exec.sv
  - source/commit_stage.sv
  - source/ooo_backend.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_ooo_backend.sv

/* sim/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// columns: op, rd, rs1, rs2, imm, idle cycles before the packet, commit stall hint
task automatic load_program();
  // one of each operation on seeded registers
  put_pkt(ALU_ADDI, 5'd1,  5'd0,  5'd0,  12'h123, 0, 0);
  put_pkt(ALU_ADDI, 5'd2,  5'd0,  5'd0,  12'hffb, 0, 0);
  put_pkt(ALU_ADDI, 5'd3,  5'd0,  5'd0,  12'h004, 0, 0);
  put_pkt(ALU_ADD,  5'd4,  5'd1,  5'd2,  12'h000, 0, 0);
  put_pkt(ALU_SUB,  5'd5,  5'd1,  5'd2,  12'h000, 1, 0);
  put_pkt(ALU_AND,  5'd6,  5'd1,  5'd2,  12'h000, 0, 0);
  put_pkt(ALU_OR,   5'd7,  5'd1,  5'd2,  12'h000, 0, 0);
  put_pkt(ALU_XOR,  5'd8,  5'd1,  5'd2,  12'h000, 2, 0);
  put_pkt(ALU_SLL,  5'd9,  5'd1,  5'd3,  12'h000, 0, 0);
  put_pkt(ALU_SRL,  5'd10, 5'd2,  5'd3,  12'h000, 0, 0);
  // shift amount comes from the low bits of 0xfffffffb
  put_pkt(ALU_SRL,  5'd11, 5'd2,  5'd2,  12'h000, 0, 0);
  put_pkt(ALU_ADDI, 5'd12, 5'd0,  5'd0,  12'h800, 0, 0);
  // back-to-back chain on one register
  put_pkt(ALU_ADDI, 5'd13, 5'd13, 5'd0,  12'h001, 0, 0);
  put_pkt(ALU_ADDI, 5'd13, 5'd13, 5'd0,  12'h001, 0, 0);
  put_pkt(ALU_ADDI, 5'd13, 5'd13, 5'd0,  12'h001, 0, 0);
  put_pkt(ALU_ADD,  5'd14, 5'd13, 5'd13, 12'h000, 0, 0);
  put_pkt(ALU_SUB,  5'd14, 5'd14, 5'd1,  12'h000, 0, 0);
  // x0 as destination and as source
  put_pkt(ALU_ADDI, 5'd0,  5'd1,  5'd0,  12'h007, 0, 0);
  put_pkt(ALU_ADD,  5'd15, 5'd0,  5'd0,  12'h000, 0, 0);
  put_pkt(ALU_OR,   5'd16, 5'd0,  5'd1,  12'h000, 0, 0);
  // long commit stalls fill the reorder buffer and the skid register
  put_pkt(ALU_ADDI, 5'd17, 5'd17, 5'd0,  12'h003, 0, 9);
  put_pkt(ALU_ADD,  5'd18, 5'd17, 5'd4,  12'h000, 0, 0);
  put_pkt(ALU_XOR,  5'd19, 5'd18, 5'd2,  12'h000, 0, 0);
  put_pkt(ALU_SLL,  5'd20, 5'd19, 5'd3,  12'h000, 0, 0);
  put_pkt(ALU_ADDI, 5'd17, 5'd17, 5'd0,  12'hfff, 0, 0);
  put_pkt(ALU_SUB,  5'd21, 5'd17, 5'd18, 12'h000, 0, 8);
  put_pkt(ALU_AND,  5'd22, 5'd21, 5'd5,  12'h000, 3, 0);
  put_pkt(ALU_OR,   5'd23, 5'd22, 5'd20, 12'h000, 0, 6);
  put_pkt(ALU_SRL,  5'd24, 5'd23, 5'd3,  12'h000, 4, 0);
  put_pkt(ALU_ADD,  5'd25, 5'd24, 5'd0,  12'h000, 0, 7);
endtask

`endif

/* sim/tb_ooo_backend.sv */
`timescale 1ns/1ps

module tb_ooo_backend
  import backend_isa_pkg::*;
();

  localparam int unsigned ROB_DEPTH    = 4;
  localparam int unsigned RESET_CYCLES = 5;

  typedef struct packed {
    alu_op_e    op;
    arch_reg_t  rd;
    arch_reg_t  rs1;
    arch_reg_t  rs2;
    imm_t       imm;
    logic [7:0] gap;
    logic [7:0] stall;
  } prog_entry_t;

  logic      clk;
  logic      rst_n;
  logic      pkt_valid_i;
  alu_op_e   pkt_op_i;
  arch_reg_t pkt_rd_i;
  arch_reg_t pkt_rs1_i;
  arch_reg_t pkt_rs2_i;
  imm_t      pkt_imm_i;
  logic      pkt_ready_o;
  logic      commit_valid_o;
  arch_reg_t commit_rd_o;
  word_t     commit_value_o;
  logic      commit_ready_i;

  prog_entry_t prog [$];
  word_t       ref_regs [NUM_ARCH_REGS];
  arch_reg_t   exp_rd_q [$];
  word_t       exp_value_q [$];
  int unsigned commits;

  ooo_backend #(.ROB_DEPTH(ROB_DEPTH)) ooo_backend_i (
    .clk, .rst_n, .pkt_valid_i, .pkt_op_i, .pkt_rd_i, .pkt_rs1_i, .pkt_rs2_i, .pkt_imm_i,
    .pkt_ready_o, .commit_valid_o, .commit_rd_o, .commit_value_o, .commit_ready_i
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  `include "tb_program.svh"

  task automatic put_pkt(input alu_op_e op, input arch_reg_t rd, input arch_reg_t rs1,
                         input arch_reg_t rs2, input imm_t imm, input int unsigned gap,
                         input int unsigned stall);
    prog_entry_t e;
    e.op    = op;
    e.rd    = rd;
    e.rs1   = rs1;
    e.rs2   = rs2;
    e.imm   = imm;
    e.gap   = 8'(gap);
    e.stall = 8'(stall);
    prog.push_back(e);
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_rd(input string name, input arch_reg_t exp, input arch_reg_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %h got %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s expected %h got %h", name, exp, act));
    end
  endtask

  // reference semantics of the toy ISA
  function automatic word_t ref_result(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD, ALU_ADDI: return a + b;
      ALU_SUB:           return a - b;
      ALU_AND:           return a & b;
      ALU_OR:            return a | b;
      ALU_XOR:           return a ^ b;
      ALU_SLL:           return a << b[4:0];
      ALU_SRL:           return a >> b[4:0];
      default:           return '0;
    endcase
  endfunction

  // architectural update in program order, x0 stays zero
  task automatic model_accept(input prog_entry_t e);
    word_t a;
    word_t b;
    word_t res;
    a = (e.rs1 == '0) ? '0 : ref_regs[e.rs1];
    if (e.op == ALU_ADDI) begin
      b = {{(WORD_W - IMM_W){e.imm[IMM_W-1]}}, e.imm};
    end else begin
      b = (e.rs2 == '0) ? '0 : ref_regs[e.rs2];
    end
    res = ref_result(e.op, a, b);
    if (e.rd != '0) begin
      ref_regs[e.rd] = res;
    end
    exp_rd_q.push_back(e.rd);
    exp_value_q.push_back(res);
  endtask

  task automatic check_commit();
    arch_reg_t exp_rd;
    word_t     exp_value;
    if (exp_rd_q.size() == 0) begin
      stop_on_error("a commit appeared with no instruction outstanding");
    end else begin
      exp_rd    = exp_rd_q.pop_front();
      exp_value = exp_value_q.pop_front();
      check_rd("commit_rd_o", exp_rd, commit_rd_o);
      check_word("commit_value_o", exp_value, commit_value_o);
      commits++;
    end
  endtask

  task automatic drive_pkt(input prog_entry_t e);
    pkt_valid_i = 1'b1;
    pkt_op_i    = e.op;
    pkt_rd_i    = e.rd;
    pkt_rs1_i   = e.rs1;
    pkt_rs2_i   = e.rs2;
    pkt_imm_i   = e.imm;
  endtask

  // between half the hint and the full hint
  function automatic int unsigned random_stall(input int unsigned hint);
    return hint - ($urandom % (hint / 2 + 1));
  endfunction

  initial begin
    int unsigned idx;
    int unsigned gap_left;
    int unsigned bp_left;
    int unsigned cycles;
    int unsigned max_stall;
    int unsigned limit;
    void'($urandom(32'h8f3c));
    rst_n          = 1'b0;
    pkt_valid_i    = 1'b0;
    pkt_op_i       = ALU_ADD;
    pkt_rd_i       = '0;
    pkt_rs1_i      = '0;
    pkt_rs2_i      = '0;
    pkt_imm_i      = '0;
    commit_ready_i = 1'b1;
    commits        = 0;
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
      ref_regs[i] = '0;
    end
    load_program();
    max_stall = 0;
    foreach (prog[i]) begin
      if (prog[i].gap + prog[i].stall > max_stall) begin
        max_stall = prog[i].gap + prog[i].stall;
      end
    end
    limit = prog.size() * (6 + max_stall);

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_bit("pkt_ready_o", 1'b1, pkt_ready_o);
    check_bit("commit_valid_o", 1'b0, commit_valid_o);

    idx      = 0;
    gap_left = prog[0].gap;
    bp_left  = 0;
    cycles   = 0;
    while (commits < prog.size()) begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        stop_on_error($sformatf("timeout after %0d cycles, only %0d of %0d commits seen",
                                cycles, commits, prog.size()));
      end
      commit_ready_i = (bp_left == 0);
      if (bp_left > 0) begin
        bp_left--;
      end
      if (idx < prog.size() && gap_left == 0) begin
        drive_pkt(prog[idx]);
      end else begin
        pkt_valid_i = 1'b0;
        if (gap_left > 0) begin
          gap_left--;
        end
      end
      // registered outputs, so both handshakes are settled until the next rising edge
      if (pkt_valid_i && pkt_ready_o) begin
        model_accept(prog[idx]);
        if (prog[idx].stall > 0) begin
          bp_left = random_stall(prog[idx].stall);
        end
        idx++;
        if (idx < prog.size()) begin
          gap_left = prog[idx].gap;
        end
      end
      if (commit_valid_o && commit_ready_i) begin
        check_commit();
      end
    end

    // nothing may commit after the program has drained
    pkt_valid_i    = 1'b0;
    commit_ready_i = 1'b1;
    repeat (8) begin
      @(negedge clk);
      if (commit_valid_o) begin
        commits++;
      end
    end

    if (commits == prog.size()) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_on_error("the number of commits does not match the program length");
    end
  end

endmodule

/* source/ooo_backend.sv */
`timescale 1ns/1ps

module ooo_backend
  import backend_isa_pkg::*;
  import backend_cfg_pkg::*;
#(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pkt_valid_i,
  input  alu_op_e   pkt_op_i,
  input  arch_reg_t pkt_rd_i,
  input  arch_reg_t pkt_rs1_i,
  input  arch_reg_t pkt_rs2_i,
  input  imm_t      pkt_imm_i,
  output logic      pkt_ready_o,
  output logic      commit_valid_o,
  output arch_reg_t commit_rd_o,
  output word_t     commit_value_o,
  input  logic      commit_ready_i
);

  logic      disp_valid, disp_ready;
  alu_op_e   disp_op;
  arch_reg_t disp_rd, disp_rs1, disp_rs2;
  imm_t      disp_imm;

  logic      rob_full, alloc_valid;
  arch_reg_t alloc_rd;
  rob_tag_t  alloc_tag, rob_rd_tag1, rob_rd_tag2;
  logic      rob_rd_done1, rob_rd_done2;
  word_t     rob_rd_value1, rob_rd_value2;

  arch_reg_t arf_raddr1, arf_raddr2;
  word_t     arf_rdata1, arf_rdata2;

  logic      ex_valid;
  alu_op_e   ex_op;
  word_t     ex_a, ex_b;
  rob_tag_t  ex_tag;

  // single result bus, the ALU is its only driver
  logic      res_valid;
  rob_tag_t  res_tag;
  word_t     res_value;

  logic      head_valid, retire;
  arch_reg_t head_rd;
  word_t     head_value;
  rob_tag_t  head_tag;

  logic      ret_valid;
  arch_reg_t ret_rd;
  rob_tag_t  ret_tag;

  pkt_intake pkt_intake_i (
    .clk, .rst_n, .pkt_valid_i, .pkt_op_i, .pkt_rd_i, .pkt_rs1_i, .pkt_rs2_i, .pkt_imm_i,
    .pkt_ready_o,
    .disp_valid_o(disp_valid), .disp_ready_i(disp_ready), .disp_op_o(disp_op),
    .disp_rd_o(disp_rd), .disp_rs1_o(disp_rs1), .disp_rs2_o(disp_rs2), .disp_imm_o(disp_imm)
  );

  rename_dispatch #(.ROB_DEPTH(ROB_DEPTH)) rename_dispatch_i (
    .clk, .rst_n,
    .disp_valid_i(disp_valid), .disp_op_i(disp_op), .disp_rd_i(disp_rd),
    .disp_rs1_i(disp_rs1), .disp_rs2_i(disp_rs2), .disp_imm_i(disp_imm),
    .disp_ready_o(disp_ready),
    .rob_full_i(rob_full), .alloc_tag_i(alloc_tag),
    .alloc_valid_o(alloc_valid), .alloc_rd_o(alloc_rd),
    .rob_rd_tag1_o(rob_rd_tag1), .rob_rd_tag2_o(rob_rd_tag2),
    .rob_rd_done1_i(rob_rd_done1), .rob_rd_done2_i(rob_rd_done2),
    .rob_rd_value1_i(rob_rd_value1), .rob_rd_value2_i(rob_rd_value2),
    .arf_raddr1_o(arf_raddr1), .arf_raddr2_o(arf_raddr2),
    .arf_rdata1_i(arf_rdata1), .arf_rdata2_i(arf_rdata2),
    .res_valid_i(res_valid), .res_tag_i(res_tag), .res_value_i(res_value),
    .ret_valid_i(ret_valid), .ret_rd_i(ret_rd), .ret_tag_i(ret_tag),
    .ex_valid_o(ex_valid), .ex_op_o(ex_op), .ex_a_o(ex_a), .ex_b_o(ex_b), .ex_tag_o(ex_tag)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) reorder_buffer_i (
    .clk, .rst_n,
    .alloc_valid_i(alloc_valid), .alloc_rd_i(alloc_rd),
    .full_o(rob_full), .alloc_tag_o(alloc_tag),
    .rd_tag1_i(rob_rd_tag1), .rd_tag2_i(rob_rd_tag2),
    .rd_done1_o(rob_rd_done1), .rd_done2_o(rob_rd_done2),
    .rd_value1_o(rob_rd_value1), .rd_value2_o(rob_rd_value2),
    .res_valid_i(res_valid), .res_tag_i(res_tag), .res_value_i(res_value),
    .head_valid_o(head_valid), .head_rd_o(head_rd), .head_value_o(head_value),
    .head_tag_o(head_tag), .retire_i(retire)
  );

  alu_exec alu_exec_i (
    .clk, .rst_n,
    .ex_valid_i(ex_valid), .ex_op_i(ex_op), .ex_a_i(ex_a), .ex_b_i(ex_b), .ex_tag_i(ex_tag),
    .res_valid_o(res_valid), .res_tag_o(res_tag), .res_value_o(res_value)
  );

  commit_stage commit_stage_i (
    .clk, .rst_n,
    .head_valid_i(head_valid), .head_rd_i(head_rd), .head_value_i(head_value),
    .head_tag_i(head_tag), .retire_o(retire),
    .ret_valid_o(ret_valid), .ret_rd_o(ret_rd), .ret_tag_o(ret_tag),
    .commit_valid_o, .commit_rd_o, .commit_value_o, .commit_ready_i,
    .arf_raddr1_i(arf_raddr1), .arf_raddr2_i(arf_raddr2),
    .arf_rdata1_o(arf_rdata1), .arf_rdata2_o(arf_rdata2)
  );

endmodule

/* source/commit_stage.sv */
`timescale 1ns/1ps

module commit_stage
  import backend_isa_pkg::*;
  import backend_cfg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      head_valid_i,
  input  arch_reg_t head_rd_i,
  input  word_t     head_value_i,
  input  rob_tag_t  head_tag_i,
  output logic      retire_o,
  output logic      ret_valid_o,
  output arch_reg_t ret_rd_o,
  output rob_tag_t  ret_tag_o,
  output logic      commit_valid_o,
  output arch_reg_t commit_rd_o,
  output word_t     commit_value_o,
  input  logic      commit_ready_i,
  input  arch_reg_t arf_raddr1_i,
  input  arch_reg_t arf_raddr2_i,
  output word_t     arf_rdata1_o,
  output word_t     arf_rdata2_o
);

  word_t arf_q [NUM_ARCH_REGS];
  logic  accept;
  logic  arf_we;

  // output register empty or draining this cycle
  assign accept = head_valid_i && (!commit_valid_o || commit_ready_i);
  assign arf_we = accept && (head_rd_i != '0);

  assign retire_o    = accept;
  assign ret_valid_o = accept;
  assign ret_rd_o    = head_rd_i;
  assign ret_tag_o   = head_tag_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      commit_valid_o <= 1'b0;
    end else if (accept) begin
      commit_valid_o <= 1'b1;
    end else if (commit_ready_i) begin
      commit_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      commit_rd_o    <= head_rd_i;
      commit_value_o <= head_value_i;
    end
  end

  // x0 is never written, so it stays at its reset zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        arf_q[i] <= '0;
      end
    end else if (arf_we) begin
      arf_q[head_rd_i] <= head_value_i;
    end
  end

  // same-cycle write goes straight to the reader
  assign arf_rdata1_o = (arf_we && head_rd_i == arf_raddr1_i) ? head_value_i
                                                              : arf_q[arf_raddr1_i];
  assign arf_rdata2_o = (arf_we && head_rd_i == arf_raddr2_i) ? head_value_i
                                                              : arf_q[arf_raddr2_i];

  a_commit_stable: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid_o && !commit_ready_i |=>
      commit_valid_o && $stable(commit_rd_o) && $stable(commit_value_o));

endmodule

/* source/alu_exec.sv */
`timescale 1ns/1ps

module alu_exec
  import backend_isa_pkg::*;
  import backend_cfg_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ex_valid_i,
  input  alu_op_e  ex_op_i,
  input  word_t    ex_a_i,
  input  word_t    ex_b_i,
  input  rob_tag_t ex_tag_i,
  output logic     res_valid_o,
  output rob_tag_t res_tag_o,
  output word_t    res_value_o
);

  word_t alu_result;

  always_comb begin
    unique case (ex_op_i)
      ALU_ADD, ALU_ADDI: alu_result = ex_a_i + ex_b_i;
      ALU_SUB:           alu_result = ex_a_i - ex_b_i;
      ALU_AND:           alu_result = ex_a_i & ex_b_i;
      ALU_OR:            alu_result = ex_a_i | ex_b_i;
      ALU_XOR:           alu_result = ex_a_i ^ ex_b_i;
      // shift amount from the low 5 bits only
      ALU_SLL:           alu_result = ex_a_i << ex_b_i[4:0];
      ALU_SRL:           alu_result = ex_a_i >> ex_b_i[4:0];
      default:           alu_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= ex_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      res_tag_o   <= ex_tag_i;
      res_value_o <= alu_result;
    end
  end

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer
  import backend_isa_pkg::*;
  import backend_cfg_pkg::*;
#(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      alloc_valid_i,
  input  arch_reg_t alloc_rd_i,
  output logic      full_o,
  output rob_tag_t  alloc_tag_o,
  input  rob_tag_t  rd_tag1_i,
  input  rob_tag_t  rd_tag2_i,
  output logic      rd_done1_o,
  output logic      rd_done2_o,
  output word_t     rd_value1_o,
  output word_t     rd_value2_o,
  input  logic      res_valid_i,
  input  rob_tag_t  res_tag_i,
  input  word_t     res_value_i,
  output logic      head_valid_o,
  output arch_reg_t head_rd_o,
  output word_t     head_value_o,
  output rob_tag_t  head_tag_o,
  input  logic      retire_i
);

  localparam int unsigned PTR_W = $clog2(ROB_DEPTH);

  if (ROB_DEPTH < 2 || ROB_DEPTH > ROB_DEPTH_MAX || (ROB_DEPTH & (ROB_DEPTH - 1)) != 0)
  begin : g_bad_depth
    $error("ROB_DEPTH must be a power of two from 2 to %0d", ROB_DEPTH_MAX);
  end

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  rob_cnt_t         count_q;

  logic      done_q  [ROB_DEPTH];
  arch_reg_t rd_q    [ROB_DEPTH];
  word_t     value_q [ROB_DEPTH];

  assign full_o      = (count_q == rob_cnt_t'(ROB_DEPTH));
  assign alloc_tag_o = rob_tag_t'(tail_q);

  // lookups only ever land on occupied entries
  assign rd_done1_o  = done_q[rd_tag1_i[PTR_W-1:0]];
  assign rd_done2_o  = done_q[rd_tag2_i[PTR_W-1:0]];
  assign rd_value1_o = value_q[rd_tag1_i[PTR_W-1:0]];
  assign rd_value2_o = value_q[rd_tag2_i[PTR_W-1:0]];

  assign head_valid_o = (count_q != '0) && done_q[head_q];
  assign head_rd_o    = rd_q[head_q];
  assign head_value_o = value_q[head_q];
  assign head_tag_o   = rob_tag_t'(head_q);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        done_q[i] <= 1'b0;
      end
    end else begin
      if (alloc_valid_i) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (res_valid_i) begin
        done_q[res_tag_i[PTR_W-1:0]] <= 1'b1;
      end
      if (retire_i) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + rob_cnt_t'(alloc_valid_i) - rob_cnt_t'(retire_i);
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (res_valid_i) begin
      value_q[res_tag_i[PTR_W-1:0]] <= res_value_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_valid_i |-> !full_o);

  a_retire_done: assert property (@(posedge clk) disable iff (!rst_n)
    retire_i |-> head_valid_o);

endmodule

/* source/rename_dispatch.sv */
`timescale 1ns/1ps

module rename_dispatch
  import backend_isa_pkg::*;
  import backend_cfg_pkg::*;
#(
  parameter int unsigned ROB_DEPTH = 8
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      disp_valid_i,
  input  alu_op_e   disp_op_i,
  input  arch_reg_t disp_rd_i,
  input  arch_reg_t disp_rs1_i,
  input  arch_reg_t disp_rs2_i,
  input  imm_t      disp_imm_i,
  output logic      disp_ready_o,
  input  logic      rob_full_i,
  input  rob_tag_t  alloc_tag_i,
  output logic      alloc_valid_o,
  output arch_reg_t alloc_rd_o,
  output rob_tag_t  rob_rd_tag1_o,
  output rob_tag_t  rob_rd_tag2_o,
  input  logic      rob_rd_done1_i,
  input  logic      rob_rd_done2_i,
  input  word_t     rob_rd_value1_i,
  input  word_t     rob_rd_value2_i,
  output arch_reg_t arf_raddr1_o,
  output arch_reg_t arf_raddr2_o,
  input  word_t     arf_rdata1_i,
  input  word_t     arf_rdata2_i,
  input  logic      res_valid_i,
  input  rob_tag_t  res_tag_i,
  input  word_t     res_value_i,
  input  logic      ret_valid_i,
  input  arch_reg_t ret_rd_i,
  input  rob_tag_t  ret_tag_i,
  output logic      ex_valid_o,
  output alu_op_e   ex_op_o,
  output word_t     ex_a_o,
  output word_t     ex_b_o,
  output rob_tag_t  ex_tag_o
);

  logic     map_busy_q [NUM_ARCH_REGS];
  rob_tag_t map_tag_q  [NUM_ARCH_REGS];

  logic  src1_ok;
  logic  src2_ok;
  word_t src1_val;
  word_t src2_val;
  word_t imm_ext;
  logic  dispatch;

  // register file, then finished rob entry, then the result bus
  function automatic logic resolve_src(input logic busy, input rob_tag_t tag,
                                       input logic rob_done, input word_t rob_val,
                                       input word_t arf_val, output word_t val);
    val = arf_val;
    if (!busy) begin
      return 1'b1;
    end
    if (rob_done) begin
      val = rob_val;
      return 1'b1;
    end
    val = res_value_i;
    return res_valid_i && (res_tag_i == tag);
  endfunction

  assign arf_raddr1_o  = disp_rs1_i;
  assign arf_raddr2_o  = disp_rs2_i;
  assign rob_rd_tag1_o = map_tag_q[disp_rs1_i];
  assign rob_rd_tag2_o = map_tag_q[disp_rs2_i];

  always_comb begin
    src1_ok = resolve_src(map_busy_q[disp_rs1_i], map_tag_q[disp_rs1_i], rob_rd_done1_i,
                          rob_rd_value1_i, arf_rdata1_i, src1_val);
    src2_ok = resolve_src(map_busy_q[disp_rs2_i], map_tag_q[disp_rs2_i], rob_rd_done2_i,
                          rob_rd_value2_i, arf_rdata2_i, src2_val);
  end

  assign imm_ext = {{(WORD_W - IMM_W){disp_imm_i[IMM_W-1]}}, disp_imm_i};

  // addi never waits on source 2
  assign disp_ready_o  = !rob_full_i && src1_ok && (src2_ok || disp_op_i == ALU_ADDI);
  assign dispatch      = disp_valid_i && disp_ready_o;
  assign alloc_valid_o = dispatch;
  assign alloc_rd_o    = disp_rd_i;

  // retire clears a stale mapping, a new dispatch to the same rd wins
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        map_busy_q[i] <= 1'b0;
      end
    end else begin
      if (ret_valid_i && map_tag_q[ret_rd_i] == ret_tag_i) begin
        map_busy_q[ret_rd_i] <= 1'b0;
      end
      if (dispatch && disp_rd_i != '0) begin
        map_busy_q[disp_rd_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch) begin
      map_tag_q[disp_rd_i] <= alloc_tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid_o <= 1'b0;
    end else begin
      ex_valid_o <= dispatch;
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch) begin
      ex_op_o  <= disp_op_i;
      ex_a_o   <= src1_val;
      ex_b_o   <= (disp_op_i == ALU_ADDI) ? imm_ext : src2_val;
      ex_tag_o <= alloc_tag_i;
    end
  end

endmodule

/* source/pkt_intake.sv */
`timescale 1ns/1ps

module pkt_intake
  import backend_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pkt_valid_i,
  input  alu_op_e   pkt_op_i,
  input  arch_reg_t pkt_rd_i,
  input  arch_reg_t pkt_rs1_i,
  input  arch_reg_t pkt_rs2_i,
  input  imm_t      pkt_imm_i,
  output logic      pkt_ready_o,
  output logic      disp_valid_o,
  input  logic      disp_ready_i,
  output alu_op_e   disp_op_o,
  output arch_reg_t disp_rd_o,
  output arch_reg_t disp_rs1_o,
  output arch_reg_t disp_rs2_o,
  output imm_t      disp_imm_o
);

  logic      skid_busy_q;
  alu_op_e   skid_op_q;
  arch_reg_t skid_rd_q;
  arch_reg_t skid_rs1_q;
  arch_reg_t skid_rs2_q;
  imm_t      skid_imm_q;

  assign pkt_ready_o  = !skid_busy_q;
  assign disp_valid_o = pkt_valid_i || skid_busy_q;

  // busy once the beat on the output was refused
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_busy_q <= 1'b0;
    end else begin
      skid_busy_q <= disp_valid_o && !disp_ready_i;
    end
  end

  // follows the live packet until busy, then holds it
  always_ff @(posedge clk) begin
    if (!skid_busy_q) begin
      skid_op_q  <= pkt_op_i;
      skid_rd_q  <= pkt_rd_i;
      skid_rs1_q <= pkt_rs1_i;
      skid_rs2_q <= pkt_rs2_i;
      skid_imm_q <= pkt_imm_i;
    end
  end

  assign disp_op_o  = skid_busy_q ? skid_op_q  : pkt_op_i;
  assign disp_rd_o  = skid_busy_q ? skid_rd_q  : pkt_rd_i;
  assign disp_rs1_o = skid_busy_q ? skid_rs1_q : pkt_rs1_i;
  assign disp_rs2_o = skid_busy_q ? skid_rs2_q : pkt_rs2_i;
  assign disp_imm_o = skid_busy_q ? skid_imm_q : pkt_imm_i;

endmodule

/* source/backend_cfg_pkg.sv */
package backend_cfg_pkg;

  // upper bound for the reorder buffer, fixes the tag width
  localparam int unsigned ROB_DEPTH_MAX = 16;
  localparam int unsigned ROB_TAG_W     = $clog2(ROB_DEPTH_MAX);

  // reorder-buffer index, also the tag carried on the result bus
  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  // occupancy count, one bit wider so a full buffer fits
  typedef logic [ROB_TAG_W:0] rob_cnt_t;

endpackage

/* source/backend_isa_pkg.sv */
package backend_isa_pkg;

  localparam int unsigned WORD_W        = 32;
  localparam int unsigned NUM_ARCH_REGS = 32;
  localparam int unsigned ARCH_REG_W    = $clog2(NUM_ARCH_REGS);
  localparam int unsigned IMM_W         = 12;

  typedef logic [WORD_W-1:0]       word_t;
  typedef logic [ARCH_REG_W-1:0]   arch_reg_t;
  typedef logic signed [IMM_W-1:0] imm_t;

  // addi takes the immediate in place of source 2
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_SLL  = 3'd5,
    ALU_SRL  = 3'd6,
    ALU_ADDI = 3'd7
  } alu_op_e;

endpackage
